/* flist.f */
+incdir+hdl
hdl/hist_pkg.sv
hdl/readout_pkg.sv
hdl/event_sequencer.sv
hdl/histogram_bank.sv
hdl/histogram_readout.sv
hdl/histogram_top.sv
tests/histogram_properties.sv
tests/histogram_tb.sv

/* Makefile */
# Verilator flow for the photon-timing histogram subsystem

TOP = histogram_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

# pass only when the testbench prints its pass line
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

/* tests/histogram_tb.sv */
`timescale 1ns/1ps

`include "hist_macros.svh"

module histogram_tb;
    import hist_pkg::*;

    localparam int FRAMES = 8;
    localparam int WAIT_LIMIT = 400;

    logic                       clk;
    logic                       res;
    logic                       event_valid;
    bin_addr_t                  event_bin;
    logic                       out_valid;
    readout_pkg::readout_word_u out_word;
    logic                       overrun;

    // one row per frame
    // columns are density, idle gap after the frame, expected drop
    // a frame right behind an accepted one with no gap ends during readout
    int frame_density [FRAMES] = '{0, 0, 1, 1, 0, 0, 1, 0};
    int frame_gap [FRAMES] = '{0, 120, 120, 0, 120, 0, 120, 120};
    bit frame_drop [FRAMES] = '{0, 1, 0, 0, 1, 0, 1, 0};

    logic [7:0]  lfsr_state;
    logic [15:0] exp_q [$];
    logic [15:0] want;
    int          hist [`PIXEL_NUM][`BIN_NUM_PER_HIS];
    int          expected_overruns = 0;
    int          overrun_count = 0;
    int          accepted_count = 0;
    int          error_count = 0;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    histogram_top uut (
        .clk         (clk),
        .res         (res),
        .event_valid (event_valid),
        .event_bin   (event_bin),
        .out_valid   (out_valid),
        .out_word    (out_word),
        .overrun     (overrun)
    );

    bind histogram_top histogram_properties u_props (
        .clk          (clk),
        .res          (res),
        .frame_done   (frame_done),
        .swap_strobe  (swap_strobe),
        .readout_busy (readout_busy),
        .out_valid    (out_valid),
        .overrun      (overrun)
    );

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("[ERROR] t=%0t ns %s", $time, msg);
        $display("Done: errors found");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at the first failure");
    endtask

    // fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // one lfsr step per bin bit, msb first
    task automatic next_bin(output bin_addr_t bin);
        bin = '0;
        for (int k = 0; k < `NB; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bin = {bin[`NB-2:0], lfsr_state[0]};
        end
    endtask

    // tag 0, pixel, bin, spare, count
    function automatic logic [15:0] count_word(input int pixel, input int bin, input int count);
        return {1'b0, pixel_idx_t'(pixel), bin_addr_t'(bin), 1'b0, bin_count_t'(count)};
    endfunction

    // tag 1, parity, pixel, peak bin, peak count
    function automatic logic [15:0] peak_word(input int parity, input int pixel, input int bin,
                                              input int count);
        return {1'b1, parity[0], pixel_idx_t'(pixel), bin_addr_t'(bin), bin_count_t'(count)};
    endfunction

    // reference stream of one accepted frame
    task automatic queue_frame_words(input int parity);
        int best_bin;
        int best_count;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            best_bin = 0;
            best_count = hist[p][0];
            for (int b = 0; b < `BIN_NUM_PER_HIS; b++) begin
                exp_q.push_back(count_word(p, b, hist[p][b]));
                // strict compare, lowest bin wins a tie
                if (hist[p][b] > best_count) begin
                    best_count = hist[p][b];
                    best_bin = b;
                end
            end
            exp_q.push_back(peak_word(parity, p, best_bin, best_count));
        end
    endtask

    // acquisitions, then pixels, then events per pixel
    task automatic drive_frame(input int density);
        bin_addr_t bin;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            for (int b = 0; b < `BIN_NUM_PER_HIS; b++) begin
                hist[p][b] = 0;
            end
        end
        for (int a = 0; a < `ACQ_NUM; a++) begin
            for (int p = 0; p < `PIXEL_NUM; p++) begin
                for (int e = 0; e < `DATA_NUM; e++) begin
                    next_bin(bin);
                    hist[p][bin]++;
                    @(posedge clk);
                    event_valid <= 1'b1;
                    event_bin <= bin;
                    // sparse frame, one idle cycle per event
                    if (density != 0) begin
                        @(posedge clk);
                        event_valid <= 1'b0;
                    end
                end
            end
        end
        @(posedge clk);
        event_valid <= 1'b0;
    endtask

    // all expected words out and every drop strobe seen
    task automatic wait_for_drain(input int frame);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || overrun_count != expected_overruns) begin
            if (cycles == WAIT_LIMIT) begin
                report_failure($sformatf(
                    "timeout after frame %0d: %0d words missing, %0d of %0d overrun strobes seen",
                    frame, exp_q.size(), overrun_count, expected_overruns));
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    // output monitor, outputs sampled at the edge after they settle
    always @(posedge clk) begin
        if (res) begin
            if (out_valid) begin
                assert (exp_q.size() != 0)
                    else report_failure("readout word appeared with no accepted frame pending");
                want = exp_q.pop_front();
                assert (out_word === want)
                    else report_mismatch($sformatf("readout word %h, expected %h",
                                                   16'(out_word), want));
            end
            if (overrun) begin
                overrun_count++;
                assert (overrun_count <= expected_overruns)
                    else report_failure("overrun strobe for a frame that should be accepted");
            end
        end
    end

    initial begin
        res = 1'b0;
        event_valid = 1'b0;
        event_bin = '0;
        lfsr_state = 8'd58;
        repeat (3) @(posedge clk);
        res <= 1'b1;
        // quiet stretch, monitor flags any early strobe
        repeat (20) @(posedge clk);
        for (int f = 0; f < FRAMES; f++) begin
            drive_frame(frame_density[f]);
            if (frame_drop[f]) begin
                expected_overruns++;
            end else begin
                // bank parity flips once per accepted frame
                queue_frame_words(accepted_count % 2);
                accepted_count++;
            end
            repeat (frame_gap[f]) @(posedge clk);
            if (frame_gap[f] != 0) begin
                wait_for_drain(f);
            end
        end
        wait_for_drain(FRAMES);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* tests/histogram_properties.sv */
`timescale 1ns/1ps

module histogram_properties (
    input logic clk,
    input logic res,
    input logic frame_done,
    input logic swap_strobe,
    input logic readout_busy,
    input logic out_valid,
    input logic overrun
);

    // goes high with the first completed frame
    logic frame_seen;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            frame_seen <= 1'b0;
        end else if (frame_done) begin
            frame_seen <= 1'b1;
        end
    end

    // the sweep starts the cycle after the swap
    a_sweep_after_swap: assert property (@(posedge clk) disable iff (!res)
        swap_strobe |=> readout_busy)
        else $error("no readout sweep in the cycle after swap_strobe");

    // words only while a sweep runs
    a_words_in_sweep: assert property (@(posedge clk) disable iff (!res)
        out_valid |-> readout_busy)
        else $error("out_valid outside a readout sweep");

    // no output stream before any frame has ended
    a_words_after_frame: assert property (@(posedge clk) disable iff (!res)
        $rose(out_valid) |-> frame_seen)
        else $error("out_valid rose before the first frame");

    // overrun is one cycle wide
    a_overrun_pulse: assert property (@(posedge clk) disable iff (!res)
        overrun |=> !overrun)
        else $error("overrun held for more than one cycle");

endmodule

/* hdl/histogram_top.sv */
`timescale 1ns/1ps

module histogram_top (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       event_valid,
    input  hist_pkg::bin_addr_t        event_bin,
    output logic                       out_valid,
    output readout_pkg::readout_word_u out_word,
    output logic                       overrun
);
    import hist_pkg::*;

    // sequencer to bank
    logic       wr_strobe;
    pixel_idx_t wr_pixel;
    bin_addr_t  wr_bin;
    logic       frame_done;

    // bank to readout
    logic       swap_strobe;
    logic       bank_parity;
    bin_count_t rd_count;

    // readout to bank
    logic       readout_busy;
    logic       rd_strobe;
    pixel_idx_t rd_pixel;
    bin_addr_t  rd_bin;

    event_sequencer u_seq (
        .clk         (clk),
        .res         (res),
        .event_valid (event_valid),
        .event_bin   (event_bin),
        .wr_strobe   (wr_strobe),
        .wr_pixel    (wr_pixel),
        .wr_bin      (wr_bin),
        .frame_done  (frame_done)
    );

    histogram_bank u_bank (
        .clk          (clk),
        .res          (res),
        .wr_strobe    (wr_strobe),
        .wr_pixel     (wr_pixel),
        .wr_bin       (wr_bin),
        .frame_done   (frame_done),
        .readout_busy (readout_busy),
        .rd_strobe    (rd_strobe),
        .rd_pixel     (rd_pixel),
        .rd_bin       (rd_bin),
        .rd_count     (rd_count),
        .swap_strobe  (swap_strobe),
        .overrun      (overrun),
        .bank_parity  (bank_parity)
    );

    histogram_readout u_readout (
        .clk          (clk),
        .res          (res),
        .swap_strobe  (swap_strobe),
        .bank_parity  (bank_parity),
        .rd_count     (rd_count),
        .rd_strobe    (rd_strobe),
        .rd_pixel     (rd_pixel),
        .rd_bin       (rd_bin),
        .readout_busy (readout_busy),
        .out_valid    (out_valid),
        .out_word     (out_word)
    );

endmodule

/* hdl/histogram_readout.sv */
`timescale 1ns/1ps

`include "hist_macros.svh"

module histogram_readout (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       swap_strobe,
    input  logic                       bank_parity,
    input  hist_pkg::bin_count_t       rd_count,
    output logic                       rd_strobe,
    output hist_pkg::pixel_idx_t       rd_pixel,
    output hist_pkg::bin_addr_t        rd_bin,
    output logic                       readout_busy,
    output logic                       out_valid,
    output readout_pkg::readout_word_u out_word
);
    import hist_pkg::*;
    import readout_pkg::*;

    localparam pixel_idx_t PIX_LAST = pixel_idx_t'(`PIXEL_NUM - 1);
    localparam bin_addr_t BIN_LAST = bin_addr_t'(`BIN_NUM_PER_HIS - 1);

    // sweep state
    logic active;
    // idle read slot after the last bin of a pixel
    logic gap;
    logic frame_parity;

    // word stage, one cycle behind the read
    logic       cnt_valid;
    logic       peak_valid;
    pixel_idx_t cnt_pixel;
    bin_addr_t  cnt_bin;

    // running maximum of the current pixel
    bin_count_t max_count;
    bin_addr_t  max_bin;

    assign rd_strobe = active & ~gap;
    // busy through the last peak word
    assign readout_busy = active | peak_valid;
    assign out_valid = cnt_valid | peak_valid;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active <= 1'b0;
            gap <= 1'b0;
            frame_parity <= 1'b0;
            rd_pixel <= '0;
            rd_bin <= '0;
            cnt_valid <= 1'b0;
            peak_valid <= 1'b0;
        end else begin
            cnt_valid <= rd_strobe;
            peak_valid <= active & gap;
            if (swap_strobe) begin
                active <= 1'b1;
                gap <= 1'b0;
                rd_pixel <= '0;
                rd_bin <= '0;
                // bank just filled, parity already toggled
                frame_parity <= ~bank_parity;
            end else if (active) begin
                if (!gap) begin
                    if (rd_bin == BIN_LAST) begin
                        gap <= 1'b1;
                        rd_bin <= '0;
                    end else begin
                        rd_bin <= rd_bin + 1'b1;
                    end
                end else begin
                    gap <= 1'b0;
                    rd_pixel <= rd_pixel + 1'b1;
                    // sweep ends after the last pixel's gap slot
                    if (rd_pixel == PIX_LAST) begin
                        active <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            cnt_pixel <= rd_pixel;
            cnt_bin <= rd_bin;
        end
        // bin 0 restarts the max
        // strict compare keeps the lower bin on ties
        if (cnt_valid && (cnt_bin == '0 || rd_count > max_count)) begin
            max_count <= rd_count;
            max_bin <= cnt_bin;
        end
    end

    // count word straight from the bank data
    always_comb begin
        out_word = '0;
        if (peak_valid) begin
            out_word.peak.tag = TAG_PEAK;
            out_word.peak.parity = frame_parity;
            out_word.peak.pixel = cnt_pixel;
            out_word.peak.peak_bin = max_bin;
            out_word.peak.peak_count = max_count;
        end else begin
            out_word.count.tag = TAG_COUNT;
            out_word.count.pixel = cnt_pixel;
            out_word.count.bin = cnt_bin;
            out_word.count.spare = 1'b0;
            out_word.count.count = rd_count;
        end
    end

endmodule

/* hdl/histogram_bank.sv */
`timescale 1ns/1ps

`include "hist_macros.svh"

module histogram_bank (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 wr_strobe,
    input  hist_pkg::pixel_idx_t wr_pixel,
    input  hist_pkg::bin_addr_t  wr_bin,
    input  logic                 frame_done,
    input  logic                 readout_busy,
    input  logic                 rd_strobe,
    input  hist_pkg::pixel_idx_t rd_pixel,
    input  hist_pkg::bin_addr_t  rd_bin,
    output hist_pkg::bin_count_t rd_count,
    output logic                 swap_strobe,
    output logic                 overrun,
    output logic                 bank_parity
);
    import hist_pkg::*;

    // entries per bank, all pixel histograms back to back
    localparam int DEPTH = `PIXEL_NUM * `BIN_NUM_PER_HIS;
    localparam int AW = `PIX_W + `NB;

    // bank_parity selects the fill bank
    // the other one belongs to readout
    bin_count_t mem [2][DEPTH];

    logic [AW-1:0] wr_idx;
    logic [AW-1:0] rd_idx;
    logic          rd_bank;

    // pixel * BIN_NUM_PER_HIS + bin
    assign wr_idx = {wr_pixel, wr_bin};
    assign rd_idx = {rd_pixel, rd_bin};
    assign rd_bank = ~bank_parity;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            bank_parity <= 1'b0;
            swap_strobe <= 1'b0;
            overrun <= 1'b0;
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else begin
            // frame end, swap only when readout is idle
            swap_strobe <= frame_done & ~readout_busy;
            overrun <= frame_done & readout_busy;

            // read-modify-write increment into the fill bank
            if (wr_strobe) begin
                mem[bank_parity][wr_idx] <= mem[bank_parity][wr_idx] + 1'b1;
            end

            // clear on read in the readout bank
            if (rd_strobe) begin
                mem[rd_bank][rd_idx] <= '0;
            end

            if (frame_done) begin
                if (readout_busy) begin
                    // dropped frame
                    // whole fill bank back to zero, overrides the last increment
                    for (int i = 0; i < DEPTH; i++) begin
                        mem[bank_parity][i] <= '0;
                    end
                end else begin
                    bank_parity <= ~bank_parity;
                end
            end
        end
    end

    // read data one cycle after rd_strobe
    always_ff @(posedge clk) begin
        if (rd_strobe) begin
            rd_count <= mem[rd_bank][rd_idx];
        end
    end

endmodule

/* hdl/event_sequencer.sv */
`timescale 1ns/1ps

`include "hist_macros.svh"

module event_sequencer (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 event_valid,
    input  hist_pkg::bin_addr_t  event_bin,
    output logic                 wr_strobe,
    output hist_pkg::pixel_idx_t wr_pixel,
    output hist_pkg::bin_addr_t  wr_bin,
    output logic                 frame_done
);
    import hist_pkg::*;

    // counter widths
    localparam int IW = $clog2(`DATA_NUM);
    localparam int QW = $clog2(`ACQ_NUM);

    // terminal counts
    localparam logic [IW-1:0] IN_LAST = IW'(`DATA_NUM - 1);
    localparam pixel_idx_t PIX_LAST = pixel_idx_t'(`PIXEL_NUM - 1);
    localparam logic [QW-1:0] ACQ_LAST = QW'(`ACQ_NUM - 1);

    // nested event position inside the frame
    logic [IW-1:0] input_count;
    pixel_idx_t    pixel_count;
    logic [QW-1:0] acq_count;

    logic input_last;
    logic pixel_last;
    logic acq_last;

    assign input_last = (input_count == IN_LAST);
    assign pixel_last = (pixel_count == PIX_LAST);
    assign acq_last = (acq_count == ACQ_LAST);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            input_count <= '0;
            pixel_count <= '0;
            acq_count <= '0;
            wr_strobe <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            // one write per accepted event
            wr_strobe <= event_valid;
            // last event of the last pixel of the last acquisition
            frame_done <= event_valid & input_last & pixel_last & acq_last;
            if (event_valid) begin
                if (input_last) begin
                    input_count <= '0;
                    if (pixel_last) begin
                        pixel_count <= '0;
                        // wraps at end of frame
                        if (acq_last) begin
                            acq_count <= '0;
                        end else begin
                            acq_count <= acq_count + 1'b1;
                        end
                    end else begin
                        pixel_count <= pixel_count + 1'b1;
                    end
                end else begin
                    input_count <= input_count + 1'b1;
                end
            end
        end
    end

    // write address, follows the event by one cycle
    always_ff @(posedge clk) begin
        if (event_valid) begin
            wr_pixel <= pixel_count;
            wr_bin <= event_bin;
        end
    end

endmodule

/* hdl/readout_pkg.sv */
package readout_pkg;

    // tag values in the top bit of every readout word
    localparam logic TAG_COUNT = 1'b0;
    localparam logic TAG_PEAK = 1'b1;

    // one bin of one pixel
    typedef struct packed {
        logic                 tag;
        hist_pkg::pixel_idx_t pixel;
        hist_pkg::bin_addr_t  bin;
        logic                 spare;
        hist_pkg::bin_count_t count;
    } count_rec_t;

    // closing word of a pixel
    // parity names the bank that was read
    typedef struct packed {
        logic                 tag;
        logic                 parity;
        hist_pkg::pixel_idx_t pixel;
        hist_pkg::bin_addr_t  peak_bin;
        hist_pkg::bin_count_t peak_count;
    } peak_rec_t;

    // the tag bit picks which view is valid
    typedef union packed {
        count_rec_t count;
        peak_rec_t  peak;
    } readout_word_u;

endpackage

/* hdl/hist_pkg.sv */
`include "hist_macros.svh"

package hist_pkg;

    // tdc bin code, also the bin address inside one histogram
    typedef logic [`NB-1:0] bin_addr_t;

    // pixel index, events arrive pixel by pixel
    typedef logic [`PIX_W-1:0] pixel_idx_t;

    // one histogram entry
    typedef logic [`PEAK_MAX-1:0] bin_count_t;

endpackage

/* hdl/hist_macros.svh */
`ifndef HIST_MACROS_SVH
`define HIST_MACROS_SVH

// bin code width delivered by the tdc front end
`define NB 4

// bins per pixel histogram, must equal 2**NB
`define BIN_NUM_PER_HIS 16

// detector pixels and pixel index width
`define PIXEL_NUM 4
`define PIX_W 2

// events per pixel in one acquisition
`define DATA_NUM 4

// acquisitions per frame
`define ACQ_NUM 2

// count width, holds DATA_NUM * ACQ_NUM without saturation
`define PEAK_MAX 8

`endif
